//--- rtl/pcie_ring_pkg.sv
// Bridge widths, register map, read patterns, FIFO depth, channel structs and write-data union
package pcie_ring_pkg;

  // Widths
  localparam int unsigned ADDR_W = 64;
  localparam int unsigned DATA_W = 64;
  localparam int unsigned TID_W  = 8;
  localparam int unsigned LEN_W  = 8;

  // Register window offsets
  localparam logic [ADDR_W-1:0] CFG_ADDR = 64'h0;
  localparam logic [ADDR_W-1:0] EXE_ADDR = 64'h100;
  localparam logic [ADDR_W-1:0] DBG_ADDR = 64'h200;
  localparam logic [ADDR_W-1:0] RST_ADDR = 64'h300;

  // Fixed read data
  localparam logic [DATA_W-1:0] DBG_PATTERN  = {(DATA_W/32){32'hdeadbeef}};
  localparam logic [DATA_W-1:0] FILL_PATTERN = {(DATA_W/32){32'hffffaaaa}};

  // Host request buffering, power of two only
  localparam int unsigned REQ_DEPTH = 64;

  // AW and AR request
  typedef struct packed {
    logic [TID_W-1:0]  id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } host_aw_t;

  // W beat
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } host_w_t;

  // One single read replayed out of a host read burst
  typedef struct packed {
    logic [TID_W-1:0]  id;
    logic [ADDR_W-1:0] addr;
    logic              last;
  } rd_req_t;

  // Ring request, reads ignore data
  typedef struct packed {
    logic [TID_W-1:0]  id;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } ring_req_t;

  // Host write word as seen by CFG or by RST
  typedef union packed {
    logic [ADDR_W-1:0] ring_addr;
    struct packed {
      logic [DATA_W-2:0] rsvd;
      logic              sw_rstn;
    } ctl;
  } wdata_u;

  // Host read data source
  typedef enum logic [1:0] {
    RSEL_CFG,
    RSEL_EXE,
    RSEL_DBG,
    RSEL_FILL
  } rsel_e;

endpackage

//--- rtl/req_fifo.sv
// Circular-buffer valid/ready FIFO for one host request channel
`timescale 1ns/1ps

module req_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 64
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             in_ready,
  output logic             head_valid,
  output logic [WIDTH-1:0] head,
  input  logic             pop
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push_en;
  logic             pop_en;

  assign in_ready   = (count != DEPTH);
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  assign push_en = in_valid && in_ready;
  assign pop_en  = pop && head_valid;

  // Entry storage
  always_ff @(posedge clk) begin
    if (push_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_en && !pop_en) begin
        count <= count + 1'b1;
      end else if (pop_en && !push_en) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- rtl/rd_burst_splitter.sv
// Read burst splitter: replays one host AR burst as a run of single reads
`timescale 1ns/1ps

module rd_burst_splitter (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     ar_valid,
  input  pcie_ring_pkg::host_aw_t  ar,
  output logic                     ar_pop,
  output logic                     rd_valid,
  output pcie_ring_pkg::rd_req_t   rd_req,
  input  logic                     rd_take
);

  import pcie_ring_pkg::*;

  // Reads still to be issued for the burst at the AR head
  logic [LEN_W:0] remain;
  logic           busy;
  logic           last_one;

  assign busy     = (remain != '0);
  assign last_one = (remain == (LEN_W+1)'(1));

  // Head stays in the FIFO until its final read is taken
  assign rd_valid    = ar_valid && busy;
  assign rd_req.id   = ar.id;
  assign rd_req.addr = ar.addr;
  assign rd_req.last = last_one;

  assign ar_pop = rd_take && rd_valid && last_one;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      remain <= '0;
    end else if (!busy) begin
      // Arm on a fresh head, len counts beats minus one
      if (ar_valid) begin
        remain <= (LEN_W+1)'(ar.len) + 1'b1;
      end
    end else if (rd_take) begin
      remain <= remain - 1'b1;
    end
  end

endmodule

//--- rtl/bridge_fsm.sv
// Bridge FSM: offset decode, ring request sequencing and host B/R responses
`timescale 1ns/1ps

module bridge_fsm (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                aw_head_valid,
  input  pcie_ring_pkg::host_aw_t             aw_head,
  input  logic                                w_head_valid,
  input  pcie_ring_pkg::host_w_t              w_head,
  output logic                                aw_pop,
  output logic                                w_pop,
  input  logic                                rd_valid,
  input  pcie_ring_pkg::rd_req_t              rd_req,
  output logic                                rd_take,
  output logic                                ring_wr_valid,
  input  logic                                ring_wr_ready,
  input  logic                                ring_b_valid,
  output logic                                ring_rd_valid,
  input  logic                                ring_rd_ready,
  input  logic                                ring_r_valid,
  output logic                                b_valid,
  input  logic                                b_ready,
  output logic                                r_valid,
  output logic                                r_last,
  input  logic                                r_ready,
  output logic                                cfg_load,
  output logic                                rst_load,
  output logic                                tid_load,
  output logic [pcie_ring_pkg::TID_W-1:0]     tid_in,
  output logic                                cap_load,
  output pcie_ring_pkg::rsel_e                rsel
);

  import pcie_ring_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WR_REQ,
    WR_WAIT,
    WR_RSP,
    RD_REQ,
    RD_WAIT,
    RD_RSP
  } state_e;

  state_e state;
  state_e state_nxt;
  rsel_e  rsel_nxt;
  logic   last_q;
  logic   wr_pending;

  assign wr_pending = aw_head_valid && w_head_valid;

  always_comb begin
    state_nxt = state;
    rsel_nxt  = rsel;
    aw_pop    = 1'b0;
    w_pop     = 1'b0;
    rd_take   = 1'b0;
    cfg_load  = 1'b0;
    rst_load  = 1'b0;
    tid_load  = 1'b0;
    tid_in    = aw_head.id;
    cap_load  = 1'b0;
    case (state)
      IDLE: begin
        // Writes win over reads
        if (wr_pending) begin
          tid_load = 1'b1;
          if (aw_head.addr == EXE_ADDR) begin
            state_nxt = WR_REQ;
          end else begin
            // Local or unmapped write, one beat per cycle
            cfg_load = (aw_head.addr == CFG_ADDR);
            rst_load = (aw_head.addr == RST_ADDR);
            w_pop    = 1'b1;
            if (w_head.last) begin
              aw_pop    = 1'b1;
              state_nxt = WR_RSP;
            end
          end
        end else if (rd_valid) begin
          rd_take  = 1'b1;
          tid_load = 1'b1;
          tid_in   = rd_req.id;
          if (rd_req.addr == EXE_ADDR) begin
            rsel_nxt  = RSEL_EXE;
            state_nxt = RD_REQ;
          end else begin
            if (rd_req.addr == CFG_ADDR) begin
              rsel_nxt = RSEL_CFG;
            end else if (rd_req.addr == DBG_ADDR) begin
              rsel_nxt = RSEL_DBG;
            end else begin
              rsel_nxt = RSEL_FILL;
            end
            state_nxt = RD_RSP;
          end
        end
      end
      WR_REQ: begin
        if (ring_wr_ready) begin
          state_nxt = WR_WAIT;
        end
      end
      WR_WAIT: begin
        // Beat retires only once the ring has completed it
        if (ring_b_valid) begin
          w_pop = 1'b1;
          if (w_head.last) begin
            aw_pop    = 1'b1;
            state_nxt = WR_RSP;
          end else begin
            state_nxt = IDLE;
          end
        end
      end
      WR_RSP: begin
        if (b_ready) begin
          state_nxt = IDLE;
        end
      end
      RD_REQ: begin
        if (ring_rd_ready) begin
          state_nxt = RD_WAIT;
        end
      end
      RD_WAIT: begin
        if (ring_r_valid) begin
          cap_load  = 1'b1;
          state_nxt = RD_RSP;
        end
      end
      RD_RSP: begin
        if (r_ready) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  assign ring_wr_valid = (state == WR_REQ);
  assign ring_rd_valid = (state == RD_REQ);
  assign b_valid       = (state == WR_RSP);
  assign r_valid       = (state == RD_RSP);
  assign r_last        = last_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state  <= IDLE;
      rsel   <= RSEL_FILL;
      last_q <= 1'b0;
    end else begin
      state <= state_nxt;
      rsel  <= rsel_nxt;
      // Burst position of the read being answered
      if (rd_take) begin
        last_q <= rd_req.last;
      end
    end
  end

endmodule

//--- rtl/cfg_regs.sv
// Ring target address, response id, captured ring data, software reset and read mux
`timescale 1ns/1ps

module cfg_regs (
  input  logic                                clk,
  input  logic                                rstn,
  input  pcie_ring_pkg::wdata_u               wdata,
  input  logic                                cfg_load,
  input  logic                                rst_load,
  input  logic                                tid_load,
  input  logic [pcie_ring_pkg::TID_W-1:0]     tid_in,
  input  logic                                cap_load,
  input  logic [pcie_ring_pkg::DATA_W-1:0]    ring_r_data,
  input  pcie_ring_pkg::rsel_e                rsel,
  output logic [pcie_ring_pkg::ADDR_W-1:0]    cfg_addr,
  output logic [pcie_ring_pkg::TID_W-1:0]     tid,
  output logic [pcie_ring_pkg::DATA_W-1:0]    r_data,
  output logic                                rst_out
);

  import pcie_ring_pkg::*;

  logic [DATA_W-1:0] cap_data;
  logic              sw_rstn;

  // Software reset stays asserted until the host releases it
  assign rst_out = ~sw_rstn;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg_addr <= '0;
      sw_rstn  <= 1'b0;
    end else begin
      if (cfg_load) begin
        cfg_addr <= wdata.ring_addr;
      end
      if (rst_load) begin
        sw_rstn <= wdata.ctl.sw_rstn;
      end
    end
  end

  // Response id and last ring read word
  always_ff @(posedge clk) begin
    if (tid_load) begin
      tid <= tid_in;
    end
    if (cap_load) begin
      cap_data <= ring_r_data;
    end
  end

  always_comb begin
    case (rsel)
      RSEL_CFG: r_data = cfg_addr;
      RSEL_EXE: r_data = cap_data;
      RSEL_DBG: r_data = DBG_PATTERN;
      default:  r_data = FILL_PATTERN;
    endcase
  end

endmodule

//--- rtl/pcie_ring_bridge.sv
// Host-to-ring bridge top: request FIFOs, read splitter, FSM and register block
`timescale 1ns/1ps

module pcie_ring_bridge (
  input  logic                                clk,
  input  logic                                rstn,
  // Host requests
  input  logic                                aw_valid,
  input  pcie_ring_pkg::host_aw_t             aw,
  output logic                                aw_ready,
  input  logic                                w_valid,
  input  pcie_ring_pkg::host_w_t              w,
  output logic                                w_ready,
  input  logic                                ar_valid,
  input  pcie_ring_pkg::host_aw_t             ar,
  output logic                                ar_ready,
  // Host responses
  output logic                                b_valid,
  output logic [pcie_ring_pkg::TID_W-1:0]     b_id,
  input  logic                                b_ready,
  output logic                                r_valid,
  output logic [pcie_ring_pkg::TID_W-1:0]     r_id,
  output logic [pcie_ring_pkg::DATA_W-1:0]    r_data,
  output logic                                r_last,
  input  logic                                r_ready,
  // Ring side
  output logic                                ring_wr_valid,
  output pcie_ring_pkg::ring_req_t            ring_req,
  input  logic                                ring_wr_ready,
  input  logic                                ring_b_valid,
  output logic                                ring_rd_valid,
  input  logic                                ring_rd_ready,
  input  logic                                ring_r_valid,
  input  logic [pcie_ring_pkg::DATA_W-1:0]    ring_r_data,
  output logic                                rst_out
);

  import pcie_ring_pkg::*;

  host_aw_t          aw_head;
  host_w_t           w_head;
  host_aw_t          ar_head;
  rd_req_t           rd_req;
  rsel_e             rsel;
  logic              aw_head_valid;
  logic              w_head_valid;
  logic              ar_head_valid;
  logic              aw_pop;
  logic              w_pop;
  logic              ar_pop;
  logic              rd_valid;
  logic              rd_take;
  logic              cfg_load;
  logic              rst_load;
  logic              tid_load;
  logic              cap_load;
  logic [TID_W-1:0]  tid_in;
  logic [TID_W-1:0]  tid;
  logic [ADDR_W-1:0] cfg_addr;

  req_fifo #(.WIDTH($bits(host_aw_t)), .DEPTH(REQ_DEPTH)) u_aw_fifo (
    .clk, .rstn,
    .in_valid(aw_valid), .in_data(aw), .in_ready(aw_ready),
    .head_valid(aw_head_valid), .head(aw_head), .pop(aw_pop)
  );

  req_fifo #(.WIDTH($bits(host_w_t)), .DEPTH(REQ_DEPTH)) u_w_fifo (
    .clk, .rstn,
    .in_valid(w_valid), .in_data(w), .in_ready(w_ready),
    .head_valid(w_head_valid), .head(w_head), .pop(w_pop)
  );

  req_fifo #(.WIDTH($bits(host_aw_t)), .DEPTH(REQ_DEPTH)) u_ar_fifo (
    .clk, .rstn,
    .in_valid(ar_valid), .in_data(ar), .in_ready(ar_ready),
    .head_valid(ar_head_valid), .head(ar_head), .pop(ar_pop)
  );

  rd_burst_splitter u_rd_split (
    .clk, .rstn,
    .ar_valid(ar_head_valid), .ar(ar_head), .ar_pop,
    .rd_valid, .rd_req, .rd_take
  );

  bridge_fsm u_fsm (
    .clk, .rstn,
    .aw_head_valid, .aw_head, .w_head_valid, .w_head, .aw_pop, .w_pop,
    .rd_valid, .rd_req, .rd_take,
    .ring_wr_valid, .ring_wr_ready, .ring_b_valid,
    .ring_rd_valid, .ring_rd_ready, .ring_r_valid,
    .b_valid, .b_ready, .r_valid, .r_last, .r_ready,
    .cfg_load, .rst_load, .tid_load, .tid_in, .cap_load, .rsel
  );

  cfg_regs u_regs (
    .clk, .rstn,
    .wdata(w_head.data), .cfg_load, .rst_load, .tid_load, .tid_in,
    .cap_load, .ring_r_data, .rsel,
    .cfg_addr, .tid, .r_data, .rst_out
  );

  // Every ring access targets the configured address
  assign ring_req.id   = aw_head.id;
  assign ring_req.addr = cfg_addr;
  assign ring_req.data = w_head.data;

  assign b_id = tid;
  assign r_id = tid;

endmodule

//--- verification/pcie_ring_bridge_chk.sv
// Concurrent handshake and reset assertions, bound to the bridge top
`timescale 1ns/1ps

module pcie_ring_bridge_chk (
  input logic                             clk,
  input logic                             rstn,
  input logic                             b_valid,
  input logic                             b_ready,
  input logic [pcie_ring_pkg::TID_W-1:0]  b_id,
  input logic                             r_valid,
  input logic                             r_ready,
  input logic [pcie_ring_pkg::TID_W-1:0]  r_id,
  input logic [pcie_ring_pkg::DATA_W-1:0] r_data,
  input logic                             r_last,
  input logic                             ring_wr_valid,
  input logic                             ring_wr_ready,
  input logic                             ring_rd_valid,
  input logic                             ring_rd_ready,
  input pcie_ring_pkg::ring_req_t         ring_req,
  input logic                             rst_out
);

  int unsigned fail_count = 0;

  // Host responses hold until accepted
  b_hold: assert property (@(posedge clk) disable iff (!rstn)
    b_valid && !b_ready |=> b_valid && $stable(b_id))
    else begin
      $error("b_valid or b_id changed before b_ready");
      fail_count++;
    end

  r_hold: assert property (@(posedge clk) disable iff (!rstn)
    r_valid && !r_ready |=> r_valid && $stable(r_id) && $stable(r_data) && $stable(r_last))
    else begin
      $error("r_valid or R payload changed before r_ready");
      fail_count++;
    end

  // Ring requests hold until the ring takes them
  ring_wr_hold: assert property (@(posedge clk) disable iff (!rstn)
    ring_wr_valid && !ring_wr_ready |=> ring_wr_valid && $stable(ring_req))
    else begin
      $error("ring write request dropped before ring_wr_ready");
      fail_count++;
    end

  ring_rd_hold: assert property (@(posedge clk) disable iff (!rstn)
    ring_rd_valid && !ring_rd_ready |=> ring_rd_valid)
    else begin
      $error("ring read request dropped before ring_rd_ready");
      fail_count++;
    end

  ring_one_op: assert property (@(posedge clk) disable iff (!rstn)
    !(ring_wr_valid && ring_rd_valid))
    else begin
      $error("ring write and read requested together");
      fail_count++;
    end

  rst_out_reset: assert property (@(posedge clk) !rstn |=> rst_out)
    else begin
      $error("rst_out low right after reset");
      fail_count++;
    end

endmodule

bind pcie_ring_bridge pcie_ring_bridge_chk u_chk (
  .clk, .rstn, .b_valid, .b_ready, .b_id, .r_valid, .r_ready, .r_id, .r_data, .r_last,
  .ring_wr_valid, .ring_wr_ready, .ring_rd_valid, .ring_rd_ready, .ring_req, .rst_out
);

//--- verification/pcie_ring_bridge_tb.sv
// Bridge testbench with host driver, ring responder model, data checks and watchdog
`timescale 1ns/1ps

module pcie_ring_bridge_tb;

  import pcie_ring_pkg::*;

  localparam int unsigned HOST_BEATS  = 15;
  localparam int unsigned BEAT_CYCLES = 200;
  localparam logic [ADDR_W-1:0] RING_A   = 64'h0000_00c0_ffee_1000;
  localparam logic [ADDR_W-1:0] UNMAPPED = 64'h400;

  logic              clk;
  logic              rstn;
  logic              aw_valid;
  host_aw_t          aw;
  logic              aw_ready;
  logic              w_valid;
  host_w_t           w;
  logic              w_ready;
  logic              ar_valid;
  host_aw_t          ar;
  logic              ar_ready;
  logic              b_valid;
  logic [TID_W-1:0]  b_id;
  logic              b_ready;
  logic              r_valid;
  logic [TID_W-1:0]  r_id;
  logic [DATA_W-1:0] r_data;
  logic              r_last;
  logic              r_ready;
  logic              ring_wr_valid;
  ring_req_t         ring_req;
  logic              ring_wr_ready;
  logic              ring_b_valid;
  logic              ring_rd_valid;
  logic              ring_rd_ready;
  logic              ring_r_valid;
  logic [DATA_W-1:0] ring_r_data;
  logic              rst_out;

  // Ring traffic seen by the responder model
  ring_req_t         wr_log[$];
  logic [ADDR_W-1:0] rd_log[$];
  logic [DATA_W-1:0] ret_log[$];
  logic [31:0]       lcg_state = 32'd75651;

  pcie_ring_bridge u_dut (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("error %s expected %h actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // Random host response stalls with ready high most of the time
  always @(posedge clk) begin : host_stall
    logic [31:0] rnd;
    rnd = next_rand();
    b_ready <= rnd[20] | rnd[21];
    r_ready <= rnd[22] | rnd[23];
  end

  // Ring responder with random ready delay and a completion pulse one cycle later
  initial begin : ring_model
    logic [31:0]       rnd;
    logic [DATA_W-1:0] word;
    logic              is_wr;
    forever begin
      @(posedge clk);
      if (rstn && (ring_wr_valid || ring_rd_valid)) begin
        is_wr = ring_wr_valid;
        rnd   = next_rand();
        repeat (rnd[17:16]) @(posedge clk);
        if (is_wr) begin
          wr_log.push_back(ring_req);
          ring_wr_ready <= 1'b1;
        end else begin
          rd_log.push_back(ring_req.addr);
          ring_rd_ready <= 1'b1;
        end
        @(posedge clk);
        ring_wr_ready <= 1'b0;
        ring_rd_ready <= 1'b0;
        if (is_wr) begin
          ring_b_valid <= 1'b1;
        end else begin
          word = {next_rand(), next_rand()};
          ret_log.push_back(word);
          ring_r_data  <= word;
          ring_r_valid <= 1'b1;
        end
        @(posedge clk);
        ring_b_valid <= 1'b0;
        ring_r_valid <= 1'b0;
      end
    end
  end

  task automatic write_burst(input string name, input logic [TID_W-1:0] id,
                             input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data[$]);
    aw_valid <= 1'b1;
    aw       <= '{id: id, addr: addr, len: LEN_W'(data.size() - 1)};
    do @(posedge clk); while (!aw_ready);
    aw_valid <= 1'b0;
    foreach (data[i]) begin
      w_valid <= 1'b1;
      w       <= '{data: data[i], last: (i == data.size() - 1)};
      do @(posedge clk); while (!w_ready);
    end
    w_valid <= 1'b0;
    do @(posedge clk); while (!(b_valid && b_ready));
    check_val({name, " bid"}, id, b_id);
  endtask

  task automatic read_burst(input string name, input logic [TID_W-1:0] id,
                            input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
                            output logic [DATA_W-1:0] got[$]);
    got = {};
    ar_valid <= 1'b1;
    ar       <= '{id: id, addr: addr, len: len};
    do @(posedge clk); while (!ar_ready);
    ar_valid <= 1'b0;
    for (int i = 0; i <= len; i++) begin
      do @(posedge clk); while (!(r_valid && r_ready));
      check_val({name, " rid"}, id, r_id);
      check_val({name, " rlast"}, (i == len), r_last);
      got.push_back(r_data);
    end
  endtask

  initial begin : main
    logic [DATA_W-1:0] beats[$];
    logic [DATA_W-1:0] got[$];
    int unsigned       n_wr;
    int unsigned       n_rd;
    int unsigned       n_ret;
    clk           = 1'b0;
    rstn          = 1'b0;
    aw_valid      = 1'b0;
    aw            = '0;
    w_valid       = 1'b0;
    w             = '0;
    ar_valid      = 1'b0;
    ar            = '0;
    b_ready       = 1'b0;
    r_ready       = 1'b0;
    ring_wr_ready = 1'b0;
    ring_b_valid  = 1'b0;
    ring_rd_ready = 1'b0;
    ring_r_valid  = 1'b0;
    ring_r_data   = '0;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    check_val("reset rst_out", 1, rst_out);

    // Config write and readback
    beats = {RING_A};
    write_burst("cfg_write", 8'h11, CFG_ADDR, beats);
    read_burst("cfg_read", 8'h22, CFG_ADDR, 8'd2, got);
    foreach (got[i]) check_val("cfg_read data", RING_A, got[i]);
    // Burst ends after its third beat
    repeat (4) begin
      @(posedge clk);
      check_val("cfg_read extra beat", 0, r_valid);
    end

    // EXE write burst gives one ring write per beat
    n_wr  = wr_log.size();
    beats = {64'h1111_0000_0000_0001, 64'h2222_0000_0000_0002,
             64'h3333_0000_0000_0003, 64'h4444_0000_0000_0004};
    write_burst("exe_write", 8'h33, EXE_ADDR, beats);
    check_val("exe_write ring count", 4, wr_log.size() - n_wr);
    foreach (beats[i]) begin
      check_val("exe_write ring addr", RING_A, wr_log[n_wr+i].addr);
      check_val("exe_write ring id", 8'h33, wr_log[n_wr+i].id);
      check_val("exe_write ring data", beats[i], wr_log[n_wr+i].data);
    end
    repeat (4) begin
      @(posedge clk);
      check_val("exe_write extra b", 0, b_valid);
    end

    // EXE read burst of two beats
    n_rd  = rd_log.size();
    n_ret = ret_log.size();
    read_burst("exe_read", 8'h44, EXE_ADDR, 8'd1, got);
    check_val("exe_read ring count", 2, rd_log.size() - n_rd);
    foreach (got[i]) begin
      check_val("exe_read ring addr", RING_A, rd_log[n_rd+i]);
      check_val("exe_read data", ret_log[n_ret+i], got[i]);
    end

    // Debug pattern, fill pattern and an unmapped write
    read_burst("dbg_read", 8'h55, DBG_ADDR, 8'd0, got);
    check_val("dbg_read data", DBG_PATTERN, got[0]);
    read_burst("fill_read", 8'h66, UNMAPPED, 8'd0, got);
    check_val("fill_read data", FILL_PATTERN, got[0]);
    n_wr  = wr_log.size();
    n_rd  = rd_log.size();
    beats = {64'h5a5a_5a5a_5a5a_5a5a};
    write_burst("unmapped_write", 8'h77, UNMAPPED, beats);
    check_val("unmapped_write ring writes", n_wr, wr_log.size());
    check_val("unmapped_write ring reads", n_rd, rd_log.size());

    // Software reset release and re-assert
    beats = {64'h1};
    write_burst("rst_release", 8'h88, RST_ADDR, beats);
    check_val("rst_release rst_out", 0, rst_out);
    beats = {64'h0};
    write_burst("rst_assert", 8'h99, RST_ADDR, beats);
    check_val("rst_assert rst_out", 1, rst_out);

    if (u_dut.u_chk.fail_count != 0) begin
      $display("sim failed");
      $fatal(1);
    end else begin
      $display("sim passed");
      $finish;
    end
  end

  // Stop at the first protocol assertion failure
  always @(posedge clk) begin
    if (u_dut.u_chk.fail_count != 0) begin
      $display("protocol assertion failed in the bound bridge checker");
      $display("sim failed");
      $fatal(1);
    end
  end

  initial begin : watchdog
    repeat (BEAT_CYCLES * HOST_BEATS + 10) @(posedge clk);
    $display("timeout: bridge stopped responding");
    $display("sim failed");
    $fatal(1);
  end

endmodule

//--- pcie_ring_bridge.f
rtl/pcie_ring_pkg.sv
rtl/req_fifo.sv
rtl/rd_burst_splitter.sv
rtl/bridge_fsm.sv
rtl/cfg_regs.sv
rtl/pcie_ring_bridge.sv
verification/pcie_ring_bridge_chk.sv
verification/pcie_ring_bridge_tb.sv

//--- Bender.yml
package:
  name: pcie_ring_bridge

sources:
  - rtl/pcie_ring_pkg.sv
  - rtl/req_fifo.sv
  - rtl/rd_burst_splitter.sv
  - rtl/bridge_fsm.sv
  - rtl/cfg_regs.sv
  - rtl/pcie_ring_bridge.sv
  - target: test
    files:
      - verification/pcie_ring_bridge_chk.sv
      - verification/pcie_ring_bridge_tb.sv
